//--- frontend_top.f
source/fetch_pkg.sv
source/bpred_pkg.sv
source/pht.sv
source/btb.sv
source/fetch_unit.sv
source/frontend_top.sv
tests/frontend_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the fetch front end testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=frontend_sim

echo "compiling with verilator"
verilator --binary --timing --assert -j 0 \
    --top-module frontend_tb \
    --Mdir "$OBJ" -o "$BIN" \
    -f frontend_top.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

echo "running simulation"
"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    echo "testbench reported a failure, see $LOG"
    exit 1
fi

echo "simulation finished without failures"
exit 0

//--- source/bpred_pkg.sv
`default_nettype none

package bpred_pkg;

    // 2-bit saturating counter, msb is the prediction
    typedef logic [1:0] ctr2_t;

    localparam ctr2_t CTR_RESET = 2'b01;
    localparam ctr2_t CTR_MAX   = 2'b11;
    localparam ctr2_t CTR_MIN   = 2'b00;

    // instructions are word aligned
    localparam int PC_ALIGN_BITS = 2;

endpackage

`default_nettype wire

//--- source/btb.sv
`timescale 1ns/1ns
`default_nettype none

module btb #(
    parameter int INDEX_W = 4,
    parameter int TAG_W   = 9
) (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic [INDEX_W-1:0] index_r_i,
    input  wire logic [TAG_W-1:0]   tag_r_i,
    input  wire logic [INDEX_W-1:0] index_w_i,
    input  wire logic [TAG_W-1:0]   tag_w_i,
    input  wire logic               update_i,
    input  wire logic [31:0]        target_i,
    output logic                    hit_o,
    output logic [31:0]             target_o
);

    localparam int DEPTH = 1 << INDEX_W;

    logic [DEPTH-1:0] valid_q;
    logic [TAG_W-1:0] tag_q    [DEPTH];
    logic [31:0]      target_q [DEPTH];

    logic             rd_valid;
    logic [TAG_W-1:0] rd_tag;
    logic [31:0]      rd_target;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (update_i) begin
            valid_q[index_w_i] <= 1'b1;
        end
    end

    // replaces the old entry at this index
    always_ff @(posedge clk) begin
        if (update_i) begin
            tag_q[index_w_i]    <= tag_w_i;
            target_q[index_w_i] <= target_i;
        end
    end

    assign rd_valid  = valid_q[index_r_i];
    assign rd_tag    = tag_q[index_r_i];
    assign rd_target = target_q[index_r_i];

    assign hit_o    = rd_valid && (rd_tag == tag_r_i);
    assign target_o = hit_o ? rd_target : 32'd0;

    // invalid entries mask the unwritten tag array
    a_hit_known: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(hit_o)
    ) else $error("btb hit is unknown after reset");

endmodule

`default_nettype wire

//--- source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // one packet per cycle towards decode
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] pred_npc;
        logic        pred_taken;
        logic        btb_hit;
    } fetch_out_t;

    // branch outcome coming back from execute
    typedef struct packed {
        logic        flush;
        // resolved next pc, also the target written into the btb
        logic [31:0] target_pc;
        logic        pht_update;
        logic [31:0] pht_pc;
        logic        taken;
        logic        btb_update;
        logic [31:0] btb_pc;
    } resolve_t;

endpackage

`default_nettype wire

//--- source/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit
    import fetch_pkg::*;
    import bpred_pkg::*;
#(
    parameter logic [31:0] RESET_PC    = 32'h3000_0000,
    parameter int          PHT_INDEX_W = 4,
    parameter int          BTB_INDEX_W = 4,
    parameter int          BTB_TAG_W   = 9
) (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire resolve_t resolve_i,
    input  wire logic     out_ready_i,
    output fetch_out_t    out_o,
    output logic          out_valid_o
);

    // tag folds in a second slice higher up the pc
    localparam int TAG_LSB      = PC_ALIGN_BITS + BTB_INDEX_W;
    localparam int TAG_FOLD_LSB = 9 + BTB_INDEX_W;

    logic [31:0]            pc_q;
    logic [31:0]            pc_d;
    logic [31:0]            pred_npc;
    logic                   fire;

    logic [PHT_INDEX_W-1:0] pht_idx_r;
    logic [PHT_INDEX_W-1:0] pht_idx_w;
    logic                   pht_taken;

    logic [BTB_INDEX_W-1:0] btb_idx_r;
    logic [BTB_INDEX_W-1:0] btb_idx_w;
    logic [BTB_TAG_W-1:0]   btb_tag_r;
    logic [BTB_TAG_W-1:0]   btb_tag_w;
    logic                   btb_hit;
    logic [31:0]            btb_target;

    function automatic logic [BTB_INDEX_W-1:0] btb_index(input logic [31:0] pc);
        return pc[PC_ALIGN_BITS +: BTB_INDEX_W] ^ pc[TAG_LSB +: BTB_INDEX_W];
    endfunction

    function automatic logic [BTB_TAG_W-1:0] btb_tag(input logic [31:0] pc);
        return pc[TAG_LSB +: BTB_TAG_W] ^ pc[TAG_FOLD_LSB +: BTB_TAG_W];
    endfunction

    assign pht_idx_r = pc_q[PC_ALIGN_BITS +: PHT_INDEX_W];
    assign pht_idx_w = resolve_i.pht_pc[PC_ALIGN_BITS +: PHT_INDEX_W];
    assign btb_idx_r = btb_index(pc_q);
    assign btb_tag_r = btb_tag(pc_q);
    assign btb_idx_w = btb_index(resolve_i.btb_pc);
    assign btb_tag_w = btb_tag(resolve_i.btb_pc);

    pht #(
        .INDEX_W (PHT_INDEX_W)
    ) u_pht (
        .clk          (clk),
        .reset        (reset),
        .index_r_i    (pht_idx_r),
        .index_w_i    (pht_idx_w),
        .update_i     (resolve_i.pht_update),
        .taken_i      (resolve_i.taken),
        .pred_taken_o (pht_taken)
    );

    btb #(
        .INDEX_W (BTB_INDEX_W),
        .TAG_W   (BTB_TAG_W)
    ) u_btb (
        .clk       (clk),
        .reset     (reset),
        .index_r_i (btb_idx_r),
        .tag_r_i   (btb_tag_r),
        .index_w_i (btb_idx_w),
        .tag_w_i   (btb_tag_w),
        .update_i  (resolve_i.btb_update),
        .target_i  (resolve_i.target_pc),
        .hit_o     (btb_hit),
        .target_o  (btb_target)
    );

    assign pred_npc    = (pht_taken && btb_hit) ? btb_target : pc_q + 32'd4;
    assign out_valid_o = !resolve_i.flush;
    assign fire        = out_valid_o && out_ready_i;

    // flush wins over a fire
    always_comb begin
        pc_d = pc_q;
        if (resolve_i.flush) begin
            pc_d = resolve_i.target_pc;
        end else if (fire) begin
            pc_d = pred_npc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign out_o.pc         = pc_q;
    assign out_o.pred_npc   = pred_npc;
    assign out_o.pred_taken = pht_taken;
    assign out_o.btb_hit    = btb_hit;

    a_flush_aligned: assert property (
        @(posedge clk) disable iff (reset)
        resolve_i.flush |-> (resolve_i.target_pc[PC_ALIGN_BITS-1:0] == '0)
    ) else $error("flush target pc is not word aligned");

    // stalled packet must not move under decode
    a_stall_hold: assert property (
        @(posedge clk) disable iff (reset)
        (out_valid_o && !out_ready_i && !resolve_i.flush) |=> $stable(pc_q)
    ) else $error("pc changed while stalled");

endmodule

`default_nettype wire

//--- source/frontend_top.sv
`timescale 1ns/1ns
`default_nettype none

module frontend_top
    import fetch_pkg::*;
#(
    parameter logic [31:0] RESET_PC    = 32'h3000_0000,
    parameter int          PHT_INDEX_W = 4,
    parameter int          BTB_INDEX_W = 4,
    parameter int          BTB_TAG_W   = 9
) (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire resolve_t resolve_i,
    input  wire logic     out_ready_i,
    output fetch_out_t    out_o,
    output logic          out_valid_o
);

    fetch_unit #(
        .RESET_PC    (RESET_PC),
        .PHT_INDEX_W (PHT_INDEX_W),
        .BTB_INDEX_W (BTB_INDEX_W),
        .BTB_TAG_W   (BTB_TAG_W)
    ) u_fetch_unit (
        .clk         (clk),
        .reset       (reset),
        .resolve_i   (resolve_i),
        .out_ready_i (out_ready_i),
        .out_o       (out_o),
        .out_valid_o (out_valid_o)
    );

endmodule

`default_nettype wire

//--- source/pht.sv
`timescale 1ns/1ns
`default_nettype none

module pht
    import bpred_pkg::*;
#(
    parameter int INDEX_W = 4
) (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic [INDEX_W-1:0] index_r_i,
    input  wire logic [INDEX_W-1:0] index_w_i,
    input  wire logic               update_i,
    input  wire logic               taken_i,
    output logic                    pred_taken_o
);

    localparam int DEPTH = 1 << INDEX_W;

    ctr2_t ctr_q [DEPTH];
    ctr2_t wr_ctr;
    ctr2_t ctr_next;

    assign wr_ctr = ctr_q[index_w_i];

    // step towards the outcome, hold at the ends
    always_comb begin
        ctr_next = wr_ctr;
        if (taken_i) begin
            if (wr_ctr != CTR_MAX) begin
                ctr_next = wr_ctr + 2'd1;
            end
        end else begin
            if (wr_ctr != CTR_MIN) begin
                ctr_next = wr_ctr - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                ctr_q[i] <= CTR_RESET;
            end
        end else if (update_i) begin
            ctr_q[index_w_i] <= ctr_next;
        end
    end

    assign pred_taken_o = ctr_q[index_r_i][1];

    // every counter gets a value during reset, so reads are always known
    a_pred_known: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(pred_taken_o)
    ) else $error("pht prediction is unknown after reset");

endmodule

`default_nettype wire

//--- tests/frontend_tb.sv
`timescale 1ns/1ns
`default_nettype none

module frontend_tb
    import fetch_pkg::*;
    import bpred_pkg::*;
;

    localparam logic [31:0] RESET_PC    = 32'h3000_0000;
    localparam int          PHT_INDEX_W = 4;
    localparam int          BTB_INDEX_W = 4;
    localparam int          BTB_TAG_W   = 9;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 4;
    localparam int DIRECTED_CYCLES = 80;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;
    localparam int TIMEOUT_NS      = (TOTAL_CYCLES + 100) * CLK_PERIOD;

    localparam int PHT_DEPTH = 1 << PHT_INDEX_W;
    localparam int BTB_DEPTH = 1 << BTB_INDEX_W;

    // directed addresses, P_ALIAS shares the btb index of P_BR but not its tag
    localparam logic [31:0] P_BR    = 32'h3000_0040;
    localparam logic [31:0] P_ALIAS = P_BR ^ 32'h0000_0044;
    localparam logic [31:0] T_BR    = 32'h3000_0200;
    localparam logic [31:0] T_ALIAS = 32'h3000_0300;

    logic       clk;
    logic       reset;
    resolve_t   resolve;
    logic       out_ready;
    fetch_out_t out;
    logic       out_valid;

    int errors;

    // reference model state
    logic [31:0]          m_pc;
    ctr2_t                m_ctr    [PHT_DEPTH];
    logic [BTB_DEPTH-1:0] m_valid;
    logic [BTB_TAG_W-1:0] m_tag    [BTB_DEPTH];
    logic [31:0]          m_target [BTB_DEPTH];

    logic        exp_taken;
    logic        exp_hit;
    logic [31:0] exp_npc;
    logic        fire;

    frontend_top #(
        .RESET_PC    (RESET_PC),
        .PHT_INDEX_W (PHT_INDEX_W),
        .BTB_INDEX_W (BTB_INDEX_W),
        .BTB_TAG_W   (BTB_TAG_W)
    ) u_dut (
        .clk         (clk),
        .reset       (reset),
        .resolve_i   (resolve),
        .out_ready_i (out_ready),
        .out_o       (out),
        .out_valid_o (out_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [PHT_INDEX_W-1:0] pht_slot(input logic [31:0] pc);
        return pc[2 +: PHT_INDEX_W];
    endfunction

    function automatic logic [BTB_INDEX_W-1:0] btb_slot(input logic [31:0] pc);
        return pc[2 +: BTB_INDEX_W] ^ pc[2 + BTB_INDEX_W +: BTB_INDEX_W];
    endfunction

    function automatic logic [BTB_TAG_W-1:0] btb_tag_of(input logic [31:0] pc);
        return pc[2 + BTB_INDEX_W +: BTB_TAG_W] ^ pc[9 + BTB_INDEX_W +: BTB_TAG_W];
    endfunction

    function automatic ctr2_t next_count(input ctr2_t c, input logic taken);
        if (taken) begin
            return (c == CTR_MAX) ? c : c + 2'd1;
        end
        return (c == CTR_MIN) ? c : c - 2'd1;
    endfunction

    assign exp_taken = m_ctr[pht_slot(m_pc)][1];
    assign exp_hit   = m_valid[btb_slot(m_pc)] && (m_tag[btb_slot(m_pc)] == btb_tag_of(m_pc));
    assign exp_npc   = (exp_taken && exp_hit) ? m_target[btb_slot(m_pc)] : m_pc + 32'd4;
    assign fire      = out_valid && out_ready;

    always @(posedge clk) begin
        if (reset) begin
            m_pc    <= RESET_PC;
            m_valid <= '0;
            for (int i = 0; i < PHT_DEPTH; i++) begin
                m_ctr[i] <= CTR_RESET;
            end
        end else begin
            if (resolve.flush) begin
                m_pc <= resolve.target_pc;
            end else if (out_ready) begin
                m_pc <= exp_npc;
            end
            if (resolve.pht_update) begin
                m_ctr[pht_slot(resolve.pht_pc)] <=
                    next_count(m_ctr[pht_slot(resolve.pht_pc)], resolve.taken);
            end
            if (resolve.btb_update) begin
                m_valid[btb_slot(resolve.btb_pc)]  <= 1'b1;
                m_tag[btb_slot(resolve.btb_pc)]    <= btb_tag_of(resolve.btb_pc);
                m_target[btb_slot(resolve.btb_pc)] <= resolve.target_pc;
            end
        end
    end

    task automatic report_error(input string msg);
        errors++;
        $display("FAILED t=%0t: %s", $time, msg);
    endtask

    a_reset_state: assert property (@(posedge clk)
        $fell(reset) |-> (out.pc == RESET_PC && !out.pred_taken && !out.btb_hit)
    ) else report_error("packet after reset is wrong");

    a_pc_model: assert property (@(posedge clk) disable iff (reset)
        out.pc == m_pc
    ) else report_error("pc differs from model");

    a_taken_model: assert property (@(posedge clk) disable iff (reset)
        out.pred_taken == exp_taken
    ) else report_error("pred_taken differs from model");

    a_hit_model: assert property (@(posedge clk) disable iff (reset)
        out.btb_hit == exp_hit
    ) else report_error("btb_hit differs from model");

    a_npc_model: assert property (@(posedge clk) disable iff (reset)
        out.pred_npc == exp_npc
    ) else report_error("pred_npc differs from model");

    a_valid_flush: assert property (@(posedge clk) disable iff (reset)
        out_valid == !resolve.flush
    ) else report_error("out_valid does not follow flush");

    a_seq_step: assert property (@(posedge clk) disable iff (reset)
        (fire && !(exp_taken && exp_hit)) |=> out.pc == $past(m_pc) + 32'd4
    ) else report_error("pc did not step by 4 after fire");

    // tables stay quiet, so the whole packet must hold
    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready && !resolve.pht_update && !resolve.btb_update)
            |=> out == $past(out)
    ) else report_error("packet moved under back-pressure");

    a_flush_redirect: assert property (@(posedge clk) disable iff (reset)
        resolve.flush |=> out.pc == $past(resolve.target_pc)
    ) else report_error("pc did not take flush target");

    a_pred_redirect: assert property (@(posedge clk) disable iff (reset)
        (fire && exp_taken && exp_hit) |=> out.pc == $past(exp_npc)
    ) else report_error("pc did not follow predicted target");

    function automatic resolve_t flush_to(input logic [31:0] target);
        resolve_t r;
        r           = '0;
        r.flush     = 1'b1;
        r.target_pc = target;
        return r;
    endfunction

    function automatic resolve_t train_pht(input logic [31:0] pc, input logic taken);
        resolve_t r;
        r            = '0;
        r.pht_update = 1'b1;
        r.pht_pc     = pc;
        r.taken      = taken;
        return r;
    endfunction

    function automatic resolve_t write_btb(input logic [31:0] pc, input logic [31:0] target);
        resolve_t r;
        r            = '0;
        r.btb_update = 1'b1;
        r.btb_pc     = pc;
        r.target_pc  = target;
        return r;
    endfunction

    task automatic apply_cycle(input logic ready, input resolve_t r);
        @(negedge clk);
        out_ready = ready;
        resolve   = r;
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        resolve_t r;
        void'($urandom(51589));
        errors    = 0;
        clk       = 1'b0;
        reset     = 1'b1;
        out_ready = 1'b0;
        resolve   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // sequential fetch, then back-pressure
        repeat (10) apply_cycle(1'b1, '0);
        repeat (5) apply_cycle(1'b0, '0);
        apply_cycle(1'b0, flush_to(32'h3000_0100));
        repeat (2) apply_cycle(1'b0, '0);
        apply_cycle(1'b1, flush_to(32'h3000_0180));
        repeat (3) apply_cycle(1'b1, '0);

        // park on the branch pc and walk its counter over both ends
        apply_cycle(1'b0, flush_to(P_BR));
        repeat (3) apply_cycle(1'b0, train_pht(P_BR, 1'b1));
        apply_cycle(1'b0, train_pht(P_BR, 1'b0));
        apply_cycle(1'b0, '0);
        repeat (3) apply_cycle(1'b0, train_pht(P_BR, 1'b0));
        apply_cycle(1'b0, '0);

        // btb fill, predicted redirect, alias miss and replacement
        apply_cycle(1'b0, write_btb(P_BR, T_BR));
        apply_cycle(1'b0, '0);
        repeat (2) apply_cycle(1'b0, train_pht(P_BR, 1'b1));
        apply_cycle(1'b0, '0);
        apply_cycle(1'b1, '0);
        apply_cycle(1'b0, flush_to(P_ALIAS));
        apply_cycle(1'b0, '0);
        apply_cycle(1'b0, write_btb(P_ALIAS, T_ALIAS));
        apply_cycle(1'b0, '0);
        apply_cycle(1'b1, '0);
        apply_cycle(1'b0, flush_to(P_BR));
        repeat (2) apply_cycle(1'b0, '0);

        // random traffic inside a 1 KiB window so entries get reused
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            r            = '0;
            r.flush      = ($urandom % 16) == 0;
            r.target_pc  = RESET_PC + ($urandom & 32'h0000_03fc);
            r.pht_update = ($urandom % 4) == 0;
            r.pht_pc     = RESET_PC + ($urandom & 32'h0000_03fc);
            r.taken      = ($urandom % 2) == 0;
            r.btb_update = ($urandom % 8) == 0;
            r.btb_pc     = RESET_PC + ($urandom & 32'h0000_03fc);
            apply_cycle(($urandom % 4) != 0, r);
        end

        repeat (3) apply_cycle(1'b1, '0);
        @(negedge clk);

        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
